//--- sim.f
source/pllPkg.sv
source/pllRegBank.sv
source/pllSerialShifter.sv
source/pllBusSlave.sv
source/pllConfigTop.sv
tb/pllClockGen.sv
tb/pllConfig_chk.sv
tb/pllConfigTb.sv

//--- source/pllBusSlave.sv
`timescale 1ns/1ns

module pllBusSlave (
    input  logic                        busClk,
    input  logic                        xferDone,
    input  logic                        cyc,
    input  logic                        stb,
    input  logic                        we,
    input  logic [pllPkg::AdrWidth-1:0] adr,
    input  logic [3:0]                  sel,
    input  logic [31:0]                 regData,
    input  logic                        busy,
    output logic                        ack,
    output logic [31:0]                 datRd,
    output logic                        wrEn,
    output logic [1:0]                  pllIdx,
    output pllPkg::pllRegSel            regSel,
    output logic                        startReq,
    output logic [1:0]                  startIdx
);

    logic req;
    logic served;    // this strobe already got its ack
    logic regKnown;
    logic mapped;
    logic isXfer;
    logic hold;
    logic ackSet;
    logic laneAny;

    // ==============================
    // address decode
    // ==============================

    assign pllIdx   = adr[pllPkg::AdrWidth-1:pllPkg::PllFieldLsb];
    assign regSel   = pllPkg::pllRegSel'(adr[pllPkg::PllFieldLsb-1:0]);
    assign regKnown = (adr[pllPkg::PllFieldLsb-1:0] <= pllPkg::regXfer);
    assign mapped   = regKnown && (pllIdx != pllPkg::PllUnmapped);
    assign isXfer   = mapped && (regSel == pllPkg::regXfer);

    // ==============================
    // handshake
    // ==============================

    assign req     = cyc && stb;
    assign laneAny = |sel;
    assign hold    = isXfer && we && busy;  // back-pressure until the shifter is free
    assign ackSet  = req && !served && !hold;

    always_ff @(posedge busClk or posedge xferDone) begin
        if (xferDone) begin
            ack    <= 1'b0;
            served <= 1'b0;
        end else begin
            ack <= ackSet;
            if (!req) begin
                served <= 1'b0;
            end else if (ackSet) begin
                served <= 1'b1;
            end
        end
    end

    // sampled on the edge that raises ack
    assign wrEn     = ackSet && we && mapped && !isXfer && laneAny;
    assign startReq = ackSet && we && isXfer && laneAny;
    assign startIdx = pllIdx;

    always_comb begin
        datRd = '0;
        if (mapped && !isXfer) begin
            datRd = regData;
            if (regSel == pllPkg::regControl) begin
                datRd[pllPkg::CtrlBusyBit] = busy;
            end
        end
    end

endmodule

//--- source/pllConfigTop.sv
`timescale 1ns/1ns

module pllConfigTop #(
    parameter int SckDivider = 4
) (
    input  logic                        busClk,
    input  logic                        xferDone,
    input  logic                        cyc,
    input  logic                        stb,
    input  logic                        we,
    input  logic [pllPkg::AdrWidth-1:0] adr,
    input  logic [3:0]                  sel,
    input  logic [31:0]                 datWr,
    output logic [31:0]                 datRd,
    output logic                        ack,
    output logic                        sck,
    output logic                        sdi,
    output logic [pllPkg::NumPll-1:0]   pllCs,
    output logic [pllPkg::NumPll-1:0]   pllEn,
    output logic [pllPkg::NumPll-1:0]   pllReset
);

    logic                         wrEn;
    logic [1:0]                   pllIdx;
    pllPkg::pllRegSel             regSel;
    logic                         startReq;
    logic [1:0]                   startIdx;
    logic [31:0]                  regData;
    logic [pllPkg::FrameBits-1:0] frameWord;
    logic                         busy;

    pllBusSlave busSlave (
        .busClk   (busClk),
        .xferDone (xferDone),
        .cyc      (cyc),
        .stb      (stb),
        .we       (we),
        .adr      (adr),
        .sel      (sel),
        .regData  (regData),
        .busy     (busy),
        .ack      (ack),
        .datRd    (datRd),
        .wrEn     (wrEn),
        .pllIdx   (pllIdx),
        .regSel   (regSel),
        .startReq (startReq),
        .startIdx (startIdx)
    );

    pllRegBank regBank (
        .busClk    (busClk),
        .xferDone  (xferDone),
        .wrEn      (wrEn),
        .pllIdx    (pllIdx),
        .regSel    (regSel),
        .datWr     (datWr),
        .sel       (sel),
        .startIdx  (startIdx),
        .regData   (regData),
        .frameWord (frameWord),
        .pllEn     (pllEn),
        .pllReset  (pllReset)
    );

    pllSerialShifter #(
        .SckDivider (SckDivider)
    ) shifter (
        .busClk    (busClk),
        .xferDone  (xferDone),
        .startReq  (startReq),
        .startIdx  (startIdx),
        .frameWord (frameWord),
        .busy      (busy),
        .sck       (sck),
        .sdi       (sdi),
        .pllCs     (pllCs)
    );

endmodule

//--- source/pllPkg.sv
package pllPkg;

    // ==============================
    // sizes
    // ==============================

    localparam int NumPll    = 3;    // synthesizers on the board
    localparam int FrameBits = 132;  // programming frame length
    localparam int GapBits   = 36;   // frame bits 32 to 67, always zero
    localparam int AdrWidth  = 6;    // wishbone word address

    // ==============================
    // address map
    // ==============================

    localparam int PllFieldLsb = 4;            // adr[5:4] picks the synthesizer
    localparam logic [1:0] PllUnmapped = 2'd3; // no fourth device

    // register offset in adr[3:0]
    typedef enum logic [3:0] {
        regBits0   = 4'd0,   // frame bits 31..0
        regBits68  = 4'd1,   // frame bits 99..68
        regBits100 = 4'd2,   // frame bits 131..100
        regControl = 4'd3,
        regXfer    = 4'd4    // write starts a frame
    } pllRegSel;

    // control word layout
    localparam int CtrlEnableBit = 0;
    localparam int CtrlBusyBit   = 1;  // read only
    localparam int CtrlResetBit  = 2;

    // ==============================
    // serial shifter
    // ==============================

    typedef enum logic [1:0] {
        stIdle,
        stLoad,
        stShift,
        stStrobe
    } shiftState;

endpackage

//--- source/pllRegBank.sv
`timescale 1ns/1ns

module pllRegBank (
    input  logic                         busClk,
    input  logic                         xferDone,
    input  logic                         wrEn,
    input  logic [1:0]                   pllIdx,
    input  pllPkg::pllRegSel             regSel,
    input  logic [31:0]                  datWr,
    input  logic [3:0]                   sel,
    input  logic [1:0]                   startIdx,
    output logic [31:0]                  regData,
    output logic [pllPkg::FrameBits-1:0] frameWord,
    output logic [pllPkg::NumPll-1:0]    pllEn,
    output logic [pllPkg::NumPll-1:0]    pllReset
);

    logic [31:0] bits0Word   [pllPkg::NumPll];
    logic [31:0] bits68Word  [pllPkg::NumPll];
    logic [31:0] bits100Word [pllPkg::NumPll];
    logic        idxValid;
    logic        startValid;

    // replace only the enabled byte lanes
    function automatic logic [31:0] mergeBytes(
        input logic [31:0] oldWord,
        input logic [31:0] newWord,
        input logic [3:0]  laneEn
    );
        logic [31:0] merged;
        merged = oldWord;
        for (int b = 0; b < 4; b++) begin
            if (laneEn[b]) begin
                merged[b*8 +: 8] = newWord[b*8 +: 8];
            end
        end
        return merged;
    endfunction

    assign idxValid   = (int'(pllIdx) < pllPkg::NumPll);
    assign startValid = (int'(startIdx) < pllPkg::NumPll);

    // ==============================
    // register writes
    // ==============================

    always_ff @(posedge busClk or posedge xferDone) begin
        if (xferDone) begin
            for (int p = 0; p < pllPkg::NumPll; p++) begin
                bits0Word[p]   <= '0;
                bits68Word[p]  <= '0;
                bits100Word[p] <= '0;
            end
            pllEn    <= '0;
            pllReset <= '0;
        end else if (wrEn && idxValid) begin
            case (regSel)
                pllPkg::regBits0: begin
                    bits0Word[pllIdx] <= mergeBytes(bits0Word[pllIdx], datWr, sel);
                end
                pllPkg::regBits68: begin
                    bits68Word[pllIdx] <= mergeBytes(bits68Word[pllIdx], datWr, sel);
                end
                pllPkg::regBits100: begin
                    bits100Word[pllIdx] <= mergeBytes(bits100Word[pllIdx], datWr, sel);
                end
                pllPkg::regControl: begin
                    if (sel[0]) begin  // control bits live in byte 0
                        pllEn[pllIdx]    <= datWr[pllPkg::CtrlEnableBit];
                        pllReset[pllIdx] <= datWr[pllPkg::CtrlResetBit];
                    end
                end
                default: ;
            endcase
        end
    end

    // ==============================
    // read mux and frame assembly
    // ==============================

    always_comb begin
        regData = '0;
        if (idxValid) begin
            case (regSel)
                pllPkg::regBits0:   regData = bits0Word[pllIdx];
                pllPkg::regBits68:  regData = bits68Word[pllIdx];
                pllPkg::regBits100: regData = bits100Word[pllIdx];
                pllPkg::regControl: begin
                    regData[pllPkg::CtrlEnableBit] = pllEn[pllIdx];
                    regData[pllPkg::CtrlResetBit]  = pllReset[pllIdx];
                end
                default: regData = '0;
            endcase
        end
    end

    // msb first on the wire, so bits100 leads
    always_comb begin
        if (startValid) begin
            frameWord = {bits100Word[startIdx],
                         bits68Word[startIdx],
                         {pllPkg::GapBits{1'b0}},
                         bits0Word[startIdx]};
        end else begin
            frameWord = '0;
        end
    end

endmodule

//--- source/pllSerialShifter.sv
`timescale 1ns/1ns

module pllSerialShifter #(
    parameter int SckDivider = 4
) (
    input  logic                         busClk,
    input  logic                         xferDone,
    input  logic                         startReq,
    input  logic [1:0]                   startIdx,
    input  logic [pllPkg::FrameBits-1:0] frameWord,
    output logic                         busy,
    output logic                         sck,
    output logic                         sdi,
    output logic [pllPkg::NumPll-1:0]    pllCs
);

    localparam int DivWidth = $clog2(SckDivider);
    localparam int CntWidth = $clog2(pllPkg::FrameBits);
    localparam int MsbPos   = pllPkg::FrameBits - 1;

    logic [DivWidth-1:0]          divCnt;
    logic                         riseTick;
    logic                         fallTick;
    pllPkg::shiftState            state;
    logic [pllPkg::FrameBits-1:0] shiftReg;
    logic [CntWidth-1:0]          bitCnt;
    logic [pllPkg::NumPll-1:0]    csMask;
    logic                         frameDone;

    // ==============================
    // sck divider
    // ==============================

    always_ff @(posedge busClk or posedge xferDone) begin
        if (xferDone) begin
            divCnt <= '0;
        end else if (fallTick) begin
            divCnt <= '0;
        end else begin
            divCnt <= divCnt + 1'b1;
        end
    end

    assign riseTick = (divCnt == DivWidth'(SckDivider / 2 - 1));  // sck goes high next edge
    assign fallTick = (divCnt == DivWidth'(SckDivider - 1));      // sck goes low next edge

    // sck only toggles while shifting
    always_ff @(posedge busClk or posedge xferDone) begin
        if (xferDone) begin
            sck <= 1'b0;
        end else if (fallTick) begin
            sck <= 1'b0;
        end else if (riseTick && state == pllPkg::stShift) begin
            sck <= 1'b1;
        end
    end

    // ==============================
    // frame state machine
    // ==============================

    always_ff @(posedge busClk or posedge xferDone) begin
        if (xferDone) begin
            state     <= pllPkg::stIdle;
            sdi       <= 1'b0;
            bitCnt    <= '0;
            frameDone <= 1'b0;
        end else begin
            frameDone <= 1'b0;
            case (state)
                pllPkg::stIdle: begin
                    if (startReq) begin
                        state <= pllPkg::stLoad;
                    end
                end
                pllPkg::stLoad: begin
                    if (fallTick) begin  // first bit out, align to sck
                        sdi    <= shiftReg[MsbPos];
                        bitCnt <= CntWidth'(pllPkg::FrameBits - 1);
                        state  <= pllPkg::stShift;
                    end
                end
                pllPkg::stShift: begin
                    if (fallTick) begin
                        if (bitCnt == '0) begin
                            sdi   <= 1'b0;
                            state <= pllPkg::stStrobe;
                        end else begin
                            sdi    <= shiftReg[MsbPos];
                            bitCnt <= bitCnt - 1'b1;
                        end
                    end
                end
                pllPkg::stStrobe: begin
                    frameDone <= 1'b1;  // latch pulse next cycle
                    state     <= pllPkg::stIdle;
                end
                default: state <= pllPkg::stIdle;
            endcase
        end
    end

    // frame payload and target device
    always_ff @(posedge busClk) begin
        if (state == pllPkg::stIdle && startReq) begin
            shiftReg <= frameWord;
            csMask   <= pllPkg::NumPll'(1) << startIdx;
        end else if (fallTick && (state == pllPkg::stLoad || state == pllPkg::stShift)) begin
            shiftReg <= shiftReg << 1;
        end
    end

    assign busy  = (state != pllPkg::stIdle);
    assign pllCs = frameDone ? csMask : '0;

endmodule

//--- tb/pllClockGen.sv
`timescale 1ns/1ns

module pllClockGen #(
    parameter int HalfPeriod  = 10,  // 20 ns busClk
    parameter int ResetCycles = 5
) (
    output logic busClk,
    output logic xferDone
);

    initial begin
        busClk = 1'b0;
        forever #HalfPeriod busClk = ~busClk;
    end

    initial begin
        xferDone = 1'b1;
        repeat (ResetCycles) @(posedge busClk);
        #2 xferDone = 1'b0;  // release away from the clock edge
    end

endmodule

//--- tb/pllConfigTb.sv
`timescale 1ns/1ns

module pllConfigTb;

    localparam int SckDivider = 4;
    localparam int XferCycles = 133 * SckDivider + 2;  // load, 132 bits, strobe

    typedef enum {opWrite, opRead, opXfer, opIdle} tbOp;

    logic         busClk;
    logic         xferDone;
    logic         cyc;
    logic         stb;
    logic         we;
    logic [5:0]   adr;
    logic [3:0]   sel;
    logic [31:0]  datWr;
    logic [31:0]  datRd;
    logic         ack;
    logic         sck;
    logic         sdi;
    logic [2:0]   pllCs;
    logic [2:0]   pllEn;
    logic [2:0]   pllReset;

    // ==============================
    // stimulus table and model
    // ==============================

    tbOp          opQ[$];
    logic [5:0]   adrQ[$];
    logic [3:0]   selQ[$];
    logic [31:0]  datQ[$];
    logic [131:0] expQ[$];
    logic [31:0]  modelWord [3][3] = '{default: '0};
    logic [2:0]   modelEn = '0;
    logic [2:0]   modelRst = '0;
    logic [131:0] frameQ[$];     // frames waiting for their strobe
    int           csQ[$];
    logic [131:0] capture;
    int           bitCount = 0;
    int           strobeCount = 0;
    int           xferAcked = 0;
    int           xferTotal = 0;
    int           errors = 0;
    int           cycleLimit = 0;
    int           cycleCnt;
    logic [31:0]  rngState;

    pllClockGen clkGen (
        .busClk   (busClk),
        .xferDone (xferDone)
    );

    pllConfigTop #(
        .SckDivider (SckDivider)
    ) uut (
        .busClk   (busClk),
        .xferDone (xferDone),
        .cyc      (cyc),
        .stb      (stb),
        .we       (we),
        .adr      (adr),
        .sel      (sel),
        .datWr    (datWr),
        .datRd    (datRd),
        .ack      (ack),
        .sck      (sck),
        .sdi      (sdi),
        .pllCs    (pllCs),
        .pllEn    (pllEn),
        .pllReset (pllReset)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic checkEq(input logic [131:0] got, input logic [131:0] exp, input string msg);
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s, got %0h, expected %0h", $time, msg, got, exp);
        end
    endtask

    // expected value follows the register map, control bits and frame layout
    task automatic addEntry(input tbOp op, input logic [5:0] a, input logic [3:0] s,
                            input logic [31:0] d);
        int           p;
        int           r;
        logic [131:0] e;
        p = a[5:4];
        r = a[3:0];
        e = '0;
        if (p < 3 && r <= 2) begin
            for (int b = 0; b < 4; b++) begin
                if (op == opWrite && s[b]) begin
                    modelWord[p][r][b*8 +: 8] = d[b*8 +: 8];
                end
            end
            e = modelWord[p][r];
        end else if (p < 3 && r == 3) begin
            if (op == opWrite && s[0]) begin
                modelEn[p]  = d[0];
                modelRst[p] = d[2];
            end
            e = {modelRst[p], 1'b0, modelEn[p]};  // busy reads zero when idle
        end
        if (op == opWrite) begin
            e = {modelRst, modelEn};
        end else if (op == opXfer) begin
            e = {modelWord[p][2], modelWord[p][1], 36'b0, modelWord[p][0]};
            xferTotal++;
        end
        opQ.push_back(op);
        adrQ.push_back(a);
        selQ.push_back(s);
        datQ.push_back(d);
        expQ.push_back(e);
    endtask

    task automatic buildTable();
        logic [5:0] unmapped [5] = '{6'h05, 6'h0F, 6'h30, 6'h32, 6'h34};
        logic [3:0] s;
        for (int i = 0; i < 12; i++) begin
            addEntry(opRead, 6'((i / 4) * 16 + i % 4), 4'hF, 32'h0);
        end
        for (int i = 0; i < 27; i++) begin
            rngState = xorshift(rngState);
            s = (i % 4 == 0) ? 4'hF : rngState[31:28];
            addEntry(opWrite, 6'((i % 3) * 16 + (i / 3) % 3), s, rngState);
            addEntry(opRead, 6'((i % 3) * 16 + (i / 3) % 3), 4'hF, 32'h0);
        end
        foreach (unmapped[k]) begin
            addEntry(opWrite, unmapped[k], 4'hF, 32'hDEAD_BEEF);
            addEntry(opRead, unmapped[k], 4'hF, 32'h0);
        end
        addEntry(opRead, 6'h14, 4'hF, 32'h0);  // transfer register reads zero
        for (int i = 0; i < 9; i++) begin
            addEntry(opRead, 6'((i / 3) * 16 + i % 3), 4'hF, 32'h0);
        end
        addEntry(opWrite, 6'h13, 4'h1, 32'h0000_0005);
        addEntry(opWrite, 6'h03, 4'h1, 32'h0000_0001);
        addEntry(opWrite, 6'h23, 4'hE, 32'h0000_0005);  // byte 0 disabled so nothing changes
        addEntry(opRead, 6'h03, 4'hF, 32'h0);
        addEntry(opRead, 6'h13, 4'hF, 32'h0);
        addEntry(opRead, 6'h23, 4'hF, 32'h0);
        addEntry(opWrite, 6'h13, 4'hF, 32'hFFFF_FFFA);
        addEntry(opRead, 6'h13, 4'hF, 32'h0);
        for (int p = 0; p < 3; p++) begin
            addEntry(opXfer, 6'(p * 16 + 4), 4'hF, 32'h0);
            addEntry(opIdle, 6'(p * 16 + 3), 4'hF, 32'h0);
        end
        // second transfer goes out while the first is still shifting
        for (int r = 0; r < 3; r++) begin
            rngState = xorshift(rngState);
            addEntry(opWrite, 6'(r), 4'hF, rngState);
        end
        addEntry(opXfer, 6'h04, 4'hF, 32'h0);
        addEntry(opXfer, 6'h24, 4'hF, 32'h0);
        addEntry(opIdle, 6'h23, 4'hF, 32'h0);
    endtask

    task automatic busCycle(input logic w, input logic [5:0] a, input logic [3:0] s,
                            input logic [31:0] d, output logic [31:0] rd);
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = w;
        adr   = a;
        sel   = s;
        datWr = d;
        do begin
            @(negedge busClk);
        end while (ack !== 1'b1);
        rd = datRd;
        @(posedge busClk);
        #2;
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
        @(posedge busClk);  // idle cycle between strobes
        #2;
    endtask

    // ==============================
    // serial capture
    // ==============================

    always @(posedge sck) begin
        capture = {capture[130:0], sdi};
        bitCount++;
    end

    always @(negedge busClk) begin
        if (xferDone === 1'b0 && pllCs !== 3'b000) begin
            if (frameQ.size() == 0) begin
                errors++;
                $display("latch strobe on pllCs %b at %0t ns with no transfer pending",
                         pllCs, $time);
            end else begin
                checkEq(pllCs, 3'b001 << csQ.pop_front(), "latch strobe device");
                checkEq(bitCount, 132, "sck rising edges in frame");
                checkEq(capture, frameQ.pop_front(), "captured frame");
            end
            strobeCount++;
            bitCount = 0;
        end
    end

    initial begin : watchdog
        cycleCnt = 0;
        wait (cycleLimit > 0);
        while (cycleCnt < cycleLimit) begin
            @(posedge busClk);
            cycleCnt++;
        end
        $display("timeout: test still running after %0d clock cycles", cycleCnt);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin : mainFlow
        logic [31:0] rd;
        cyc      = 1'b0;
        stb      = 1'b0;
        we       = 1'b0;
        adr      = '0;
        sel      = '0;
        datWr    = '0;
        rngState = 32'h8a35;
        buildTable();
        cycleLimit = 4 * xferTotal * XferCycles + 2000;
        @(negedge xferDone);
        @(posedge busClk);
        #2;
        checkEq({ack, pllCs, pllEn, pllReset, sck, sdi}, '0, "outputs after reset");
        for (int i = 0; i < opQ.size(); i++) begin
            case (opQ[i])
                opWrite: begin
                    busCycle(1'b1, adrQ[i], selQ[i], datQ[i], rd);
                    checkEq({pllReset, pllEn}, expQ[i], $sformatf("pins after entry %0d", i));
                end
                opRead: begin
                    busCycle(1'b0, adrQ[i], selQ[i], datQ[i], rd);
                    checkEq(rd, expQ[i], $sformatf("read entry %0d adr %h", i, adrQ[i]));
                end
                opXfer: begin
                    busCycle(1'b1, adrQ[i], selQ[i], datQ[i], rd);
                    checkEq(strobeCount, xferAcked, "earlier frames strobed before ack");
                    frameQ.push_back(expQ[i]);
                    csQ.push_back(int'(adrQ[i][5:4]));
                    xferAcked++;
                end
                opIdle: begin
                    do begin
                        busCycle(1'b0, adrQ[i], selQ[i], datQ[i], rd);
                    end while (rd[pllPkg::CtrlBusyBit] === 1'b1);
                    checkEq(rd, expQ[i], $sformatf("control after frame, entry %0d", i));
                    checkEq(strobeCount, xferAcked, "strobes once busy cleared");
                end
            endcase
        end
        $display("end of test: %0d errors, %0d frames strobed", errors, strobeCount);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- tb/pllConfig_chk.sv
`timescale 1ns/1ns

module pllConfig_chk (
    input logic                      busClk,
    input logic                      xferDone,
    input logic                      ack,
    input logic                      busy,
    input logic                      sck,
    input logic [pllPkg::NumPll-1:0] pllCs
);

    // ==============================
    // wishbone and serial protocol
    // ==============================

    ackSingle: assert property (@(posedge busClk) disable iff (xferDone) ack |=> !ack)
        else $error("ack high on two consecutive cycles");

    csOneHot: assert property (@(posedge busClk) disable iff (xferDone) $onehot0(pllCs))
        else $error("more than one pllCs bit high");

    sckQuiet: assert property (@(posedge busClk) disable iff (xferDone) !busy |-> !sck)
        else $error("sck high while the shifter is idle");

endmodule

bind pllConfigTop pllConfig_chk chk (
    .busClk   (busClk),
    .xferDone (xferDone),
    .ack      (ack),
    .busy     (busy),
    .sck      (sck),
    .pllCs    (pllCs)
);
